// File: rtl/rv32i_pkg.sv
// rv32i core package: data widths, major opcodes and ALU operation encodings
package rv32i_pkg;

    localparam int XLEN       = 32;  // register and datapath width
    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int NUM_REGS   = 32;  // integer register count

    // major opcodes the core accepts, everything else decodes as illegal
    typedef enum logic [6:0] {
        OP_RTYPE = 7'b0110011,  // register-register alu
        OP_ITYPE = 7'b0010011,  // register-immediate alu
        OP_LUI   = 7'b0110111,  // load upper immediate
        OP_AUIPC = 7'b0010111   // add upper immediate to pc
    } opcode_t;

    // operation carried from decode to execute
    typedef enum logic [3:0] {
        ALU_ADD     = 4'd0,
        ALU_SUB     = 4'd1,
        ALU_SLL     = 4'd2,
        ALU_SLT     = 4'd3,   // signed compare
        ALU_SLTU    = 4'd4,   // unsigned compare
        ALU_XOR     = 4'd5,
        ALU_SRL     = 4'd6,
        ALU_SRA     = 4'd7,   // arithmetic shift keeps sign
        ALU_OR      = 4'd8,
        ALU_AND     = 4'd9,
        ALU_LUI     = 4'd10,  // result is the immediate itself
        ALU_AUIPC   = 4'd11,  // result is pc + immediate
        ALU_ILLEGAL = 4'd12   // no writeback, flagged at retire
    } alu_op_t;

endpackage

// File: rtl/rv32i_decoded_if.sv
// decoded instruction link: one instruction plus valid/stall levels between core blocks
`timescale 1ns/1ps

interface rv32i_decoded_if import rv32i_pkg::*; ();

    logic                  valid;    // payload below is meaningful
    logic                  stall;    // receiver cannot take it this cycle
    alu_op_t               op;       // operation to perform
    logic [REG_ADDR_W-1:0] rd;       // destination register
    logic [REG_ADDR_W-1:0] rs1;      // first source
    logic [REG_ADDR_W-1:0] rs2;      // second source, unused with imm
    logic [XLEN-1:0]       imm;      // already sign or shift extended
    logic                  use_imm;  // second operand is imm, not rs2
    logic [XLEN-1:0]       pc;       // address the word came from

    // producer side
    modport src (output valid, op, rd, rs1, rs2, imm, use_imm, pc, input stall);

    // consumer side
    modport dst (input valid, op, rd, rs1, rs2, imm, use_imm, pc, output stall);

endinterface

// File: rtl/rv32i_fetch_decode.sv
// fetch/decode: instruction bus master, sequential pc and rv32i alu-subset decoder
`timescale 1ns/1ps

module rv32i_fetch_decode import rv32i_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET = '0  // first fetch address
) (
    input  logic            i_clk,
    input  logic            i_reset,
    input  logic [XLEN-1:0] i_inst,      // word returned by memory
    input  logic            i_ack_inst,  // one-cycle pulse with i_inst
    output logic [XLEN-1:0] o_iaddr,     // held while request is open
    output logic            o_stb_inst,  // level request
    rv32i_decoded_if.src    o_dec
);

    typedef enum logic {
        IDLE,      // no request open
        WAIT_ACK   // request open, waiting for memory
    } state_t;

    state_t          state;
    logic [XLEN-1:0] pc;
    logic            out_free;   // output reg empty or draining this edge
    logic            out_clear;  // empty and queue has room, word can't get stuck

    opcode_t               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    alu_op_t               dec_op;
    logic [XLEN-1:0]       dec_imm;
    logic                  dec_use_imm;
    logic [REG_ADDR_W-1:0] dec_rs1;

    assign out_free  = !o_dec.valid || !o_dec.stall;
    assign out_clear = !o_dec.valid && !o_dec.stall;

    assign o_stb_inst = (state == WAIT_ACK);
    assign o_iaddr    = pc;  // only moves on ack, so stable under stb

    // request fsm; a word is only requested when its ack can be absorbed
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (out_free) state <= WAIT_ACK;
                WAIT_ACK: begin
                    if (i_ack_inst) begin
                        // chain straight on when the new word will drain next edge
                        state <= out_clear ? WAIT_ACK : IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= PC_RESET;
        end else if (i_ack_inst) begin
            pc <= pc + XLEN'(4);  // no redirection, straight line only
        end
    end

    assign opcode = opcode_t'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    always_comb begin
        dec_op      = ALU_ILLEGAL;
        dec_imm     = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};  // i-type default
        dec_use_imm = 1'b1;
        dec_rs1     = i_inst[19:15];
        case (opcode)
            OP_RTYPE: begin
                dec_use_imm = 1'b0;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  dec_op = ALU_ADD;
                        3'b001:  dec_op = ALU_SLL;
                        3'b010:  dec_op = ALU_SLT;
                        3'b011:  dec_op = ALU_SLTU;
                        3'b100:  dec_op = ALU_XOR;
                        3'b101:  dec_op = ALU_SRL;
                        3'b110:  dec_op = ALU_OR;
                        default: dec_op = ALU_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) dec_op = ALU_SUB;
                    if (funct3 == 3'b101) dec_op = ALU_SRA;
                end
            end
            OP_ITYPE: begin
                case (funct3)
                    3'b000: dec_op = ALU_ADD;
                    3'b010: dec_op = ALU_SLT;
                    3'b011: dec_op = ALU_SLTU;
                    3'b100: dec_op = ALU_XOR;
                    3'b110: dec_op = ALU_OR;
                    3'b111: dec_op = ALU_AND;
                    3'b001: if (funct7 == 7'b0000000) dec_op = ALU_SLL;
                    default: begin  // 101, srli or srai by funct7
                        if (funct7 == 7'b0000000) dec_op = ALU_SRL;
                        if (funct7 == 7'b0100000) dec_op = ALU_SRA;
                    end
                endcase
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    dec_imm = {{(XLEN-5){1'b0}}, i_inst[24:20]};  // shamt only
                end
            end
            OP_LUI, OP_AUIPC: begin
                dec_op  = (opcode == OP_LUI) ? ALU_LUI : ALU_AUIPC;
                dec_imm = {i_inst[31:12], 12'b0};  // upper 20 bits
                dec_rs1 = '0;                      // no source register
            end
            default: dec_op = ALU_ILLEGAL;
        endcase
    end

    // output register valid level
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_dec.valid <= 1'b0;
        end else if (i_ack_inst) begin
            o_dec.valid <= 1'b1;  // always free here, fsm guarantees it
        end else if (!o_dec.stall) begin
            o_dec.valid <= 1'b0;  // item moved on
        end
    end

    // payload, only loaded on ack so it holds while stalled
    always_ff @(posedge i_clk) begin
        if (i_ack_inst) begin
            o_dec.op      <= dec_op;
            o_dec.rd      <= i_inst[11:7];
            o_dec.rs1     <= dec_rs1;
            o_dec.rs2     <= i_inst[24:20];
            o_dec.imm     <= dec_imm;
            o_dec.use_imm <= dec_use_imm;
            o_dec.pc      <= pc;
        end
    end

endmodule

// File: rtl/rv32i_inst_queue.sv
// instruction queue: circular FIFO of decoded instructions between decode and execute
`timescale 1ns/1ps

module rv32i_inst_queue import rv32i_pkg::*; #(
    parameter int QUEUE_DEPTH = 4  // power of two, at least 2
) (
    input  logic         i_clk,
    input  logic         i_reset,
    rv32i_decoded_if.dst i_dec,
    rv32i_decoded_if.src o_exe
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    typedef struct packed {
        alu_op_t               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        logic                  use_imm;
        logic [XLEN-1:0]       pc;
    } entry_t;

    entry_t           mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // 0..QUEUE_DEPTH
    logic             push;
    logic             pop;
    entry_t           head;

    assign push = i_dec.valid && !i_dec.stall;
    assign pop  = o_exe.valid && !o_exe.stall;

    assign i_dec.stall = (count == (PTR_W + 1)'(QUEUE_DEPTH));  // full
    assign o_exe.valid = (count != '0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)      count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= '{op: i_dec.op, rd: i_dec.rd, rs1: i_dec.rs1, rs2: i_dec.rs2,
                             imm: i_dec.imm, use_imm: i_dec.use_imm, pc: i_dec.pc};
        end
    end

    // head entry is stable until popped
    assign head          = mem[rd_ptr];
    assign o_exe.op      = head.op;
    assign o_exe.rd      = head.rd;
    assign o_exe.rs1     = head.rs1;
    assign o_exe.rs2     = head.rs2;
    assign o_exe.imm     = head.imm;
    assign o_exe.use_imm = head.use_imm;
    assign o_exe.pc      = head.pc;

endmodule

// File: rtl/rv32i_execute.sv
// execute: register file, alu, writeback and retire/illegal reporting
`timescale 1ns/1ps

module rv32i_execute import rv32i_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_halt,          // hold off consumption
    rv32i_decoded_if.dst          i_exe,
    output logic                  o_retire_valid,  // one pulse per retired instr
    output logic [XLEN-1:0]       o_retire_pc,
    output logic [REG_ADDR_W-1:0] o_retire_rd,
    output logic [XLEN-1:0]       o_retire_data,
    output logic                  o_illegal        // pulse, pc on o_retire_pc
);

    logic [XLEN-1:0] regs [NUM_REGS];  // regs[0] never written
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            move;
    logic            is_illegal;
    logic            wr_en;

    assign i_exe.stall = i_halt;
    assign move        = i_exe.valid && !i_halt;
    assign is_illegal  = (i_exe.op == ALU_ILLEGAL);
    assign wr_en       = move && !is_illegal && (i_exe.rd != '0);

    // read in the consuming cycle, so a write on the previous edge is already visible
    assign op_a    = (i_exe.rs1 == '0) ? '0 : regs[i_exe.rs1];
    assign rs2_val = (i_exe.rs2 == '0) ? '0 : regs[i_exe.rs2];
    assign op_b    = i_exe.use_imm ? i_exe.imm : rs2_val;

    always_comb begin
        case (i_exe.op)
            ALU_ADD:   result = op_a + op_b;
            ALU_SUB:   result = op_a - op_b;
            ALU_SLL:   result = op_a << op_b[4:0];
            ALU_SLT:   result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            ALU_SLTU:  result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
            ALU_XOR:   result = op_a ^ op_b;
            ALU_SRL:   result = op_a >> op_b[4:0];
            ALU_SRA:   result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:    result = op_a | op_b;
            ALU_AND:   result = op_a & op_b;
            ALU_LUI:   result = i_exe.imm;
            ALU_AUIPC: result = i_exe.pc + i_exe.imm;
            default:   result = '0;  // illegal, nothing written
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            regs[i_exe.rd] <= result;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_retire_valid <= 1'b0;
            o_illegal      <= 1'b0;
        end else begin
            o_retire_valid <= move && !is_illegal;
            o_illegal      <= move && is_illegal;
        end
    end

    // retire payload, held between reports
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_retire_pc   <= '0;
            o_retire_rd   <= '0;
            o_retire_data <= '0;
        end else if (move) begin
            o_retire_pc   <= i_exe.pc;
            o_retire_rd   <= i_exe.rd;
            o_retire_data <= (i_exe.rd == '0) ? '0 : result;  // x0 reports zero
        end
    end

endmodule

// File: rtl/rv32i_core.sv
// rv32i core top: fetch/decode, instruction queue and execute joined by decoded links
`timescale 1ns/1ps

module rv32i_core import rv32i_pkg::*; #(
    parameter logic [XLEN-1:0] PC_RESET    = '0,  // first fetch address
    parameter int              QUEUE_DEPTH = 4    // decoded instr buffer entries
) (
    input  logic                  i_clk,
    input  logic                  i_reset,
    // instruction bus
    input  logic [XLEN-1:0]       i_inst,
    output logic [XLEN-1:0]       o_iaddr,
    output logic                  o_stb_inst,
    input  logic                  i_ack_inst,
    // back-pressure from outside
    input  logic                  i_halt,
    // retire report
    output logic                  o_retire_valid,
    output logic [XLEN-1:0]       o_retire_pc,
    output logic [REG_ADDR_W-1:0] o_retire_rd,
    output logic [XLEN-1:0]       o_retire_data,
    output logic                  o_illegal
);

    rv32i_decoded_if dec_link ();  // decode -> queue
    rv32i_decoded_if exe_link ();  // queue -> execute

    rv32i_fetch_decode #(.PC_RESET(PC_RESET)) u_fetch_decode (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_inst     (i_inst),
        .i_ack_inst (i_ack_inst),
        .o_iaddr    (o_iaddr),
        .o_stb_inst (o_stb_inst),
        .o_dec      (dec_link.src)
    );

    rv32i_inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_inst_queue (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_dec   (dec_link.dst),
        .o_exe   (exe_link.src)
    );

    rv32i_execute u_execute (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_halt         (i_halt),
        .i_exe          (exe_link.dst),
        .o_retire_valid (o_retire_valid),
        .o_retire_pc    (o_retire_pc),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_illegal      (o_illegal)
    );

endmodule

// File: tb/rv32i_core_sva.sv
// rv32i core protocol checks: instruction bus address hold and retire port rules
`timescale 1ns/1ps

module rv32i_core_sva import rv32i_pkg::*; (
    input logic                  i_clk,
    input logic                  i_reset,
    input logic                  o_stb_inst,
    input logic                  i_ack_inst,
    input logic [XLEN-1:0]       o_iaddr,
    input logic                  o_retire_valid,
    input logic                  o_illegal,
    input logic [REG_ADDR_W-1:0] o_retire_rd,
    input logic [XLEN-1:0]       o_retire_data
);

    // open request keeps its address until memory answers
    iaddr_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_stb_inst && !i_ack_inst) |=> $stable(o_iaddr))
        else $error("o_iaddr moved while a fetch request was open");

    // an instruction either retires or is flagged, never both
    retire_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_retire_valid && o_illegal))
        else $error("o_retire_valid and o_illegal high in the same cycle");

    // x0 destination always reports zero
    x0_zero: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_retire_valid && o_retire_rd == '0) |-> (o_retire_data == '0))
        else $error("retire to x0 carried nonzero data");

endmodule

bind rv32i_core rv32i_core_sva sva (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .o_stb_inst     (o_stb_inst),
    .i_ack_inst     (i_ack_inst),
    .o_iaddr        (o_iaddr),
    .o_retire_valid (o_retire_valid),
    .o_illegal      (o_illegal),
    .o_retire_rd    (o_retire_rd),
    .o_retire_data  (o_retire_data)
);

// File: tb/tb_rv32i_core.sv
// rv32i core testbench: instruction memory model, reference register model, directed tests
`timescale 1ns/1ps

module tb_rv32i_core;

    localparam logic [31:0] PC_BASE     = 32'h0000_0100;  // nonzero start address
    localparam int          QUEUE_DEPTH = 4;
    localparam int          PROG_WORDS  = 48;  // program capacity, also sizes the watchdog
    localparam int          CLK_HALF    = 20;  // 40 ns period

    logic        i_clk;
    logic        i_reset;
    logic [31:0] i_inst;
    logic [31:0] o_iaddr;
    logic        o_stb_inst;
    logic        i_ack_inst;
    logic        i_halt;
    logic        o_retire_valid;
    logic [31:0] o_retire_pc;
    logic [4:0]  o_retire_rd;
    logic [31:0] o_retire_data;
    logic        o_illegal;

    logic [31:0] prog [PROG_WORDS];  // words appended by the tests
    int          prog_len;           // words available to the memory model
    int          ack_count;          // words handed to the core
    logic [31:0] ref_regs [32];      // expected architectural state, x0 stays 0
    logic [31:0] lcg_state;          // memory delay generator
    logic        halted;             // no retire allowed while set

    logic [31:0] exp_pc [$];         // expected retire stream, program order
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic        exp_ill [$];

    rv32i_core #(.PC_RESET(PC_BASE), .QUEUE_DEPTH(QUEUE_DEPTH)) dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_inst         (i_inst),
        .o_iaddr        (o_iaddr),
        .o_stb_inst     (o_stb_inst),
        .i_ack_inst     (i_ack_inst),
        .i_halt         (i_halt),
        .o_retire_valid (o_retire_valid),
        .o_retire_pc    (o_retire_pc),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_illegal      (o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #CLK_HALF i_clk = ~i_clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, expected));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // rv32i integer ops by funct3, alt picks sub or sra
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return (a[31] != b[31]) ? {31'd0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{a[31]}})
                                : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_word(input logic [31:0] word, input logic ill, input logic [4:0] rd,
                            input logic [31:0] value);
        if (prog_len >= PROG_WORDS) begin
            fail_run("test program does not fit the instruction memory model");
        end else begin
            prog[prog_len] = word;
            exp_pc.push_back(PC_BASE + 32'(prog_len * 4));
            exp_ill.push_back(ill);
            exp_rd.push_back(rd);
            exp_data.push_back((rd == 5'd0) ? 32'd0 : value);
            if (!ill && rd != 5'd0) ref_regs[rd] = value;  // illegal leaves state alone
            prog_len++;
        end
    endtask

    task automatic put_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        add_word(enc_r(f7, rs2, rs1, f3, rd), 1'b0, rd,
                 ref_alu(f3, f7[5], ref_regs[rs1], ref_regs[rs2]));
    endtask

    task automatic put_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [11:0] imm);
        logic [31:0] b;
        logic        alt;
        b   = (f3 == 3'b001 || f3 == 3'b101) ? {27'd0, imm[4:0]} : {{20{imm[11]}}, imm};
        alt = (f3 == 3'b101) && imm[10];  // srai marker bit
        add_word(enc_i(imm, rs1, f3, rd), 1'b0, rd, ref_alu(f3, alt, ref_regs[rs1], b));
    endtask

    task automatic put_upper(input logic is_lui, input logic [4:0] rd, input logic [19:0] imm);
        logic [31:0] pc_here;
        pc_here = PC_BASE + 32'(prog_len * 4);
        add_word({imm, rd, is_lui ? 7'b0110111 : 7'b0010111}, 1'b0, rd,
                 is_lui ? {imm, 12'd0} : pc_here + {imm, 12'd0});
    endtask

    task automatic wait_retired(input int max_cycles);
        int n;
        n = 0;
        while (exp_pc.size() != 0 && n < max_cycles) begin
            @(negedge i_clk);
            n++;
        end
        if (exp_pc.size() != 0) fail_run("timed out waiting for instructions to retire");
    endtask

    // memory answers each request after 0..3 cycles, only for words already written
    initial begin : memory_model
        int delay;
        forever begin
            @(posedge i_clk);
            #1;
            i_ack_inst = 1'b0;
            if (!i_reset && o_stb_inst && ack_count < prog_len) begin
                delay = int'(lcg_next() >> 16) % 4;
                repeat (delay) begin
                    @(posedge i_clk);
                    #1;
                end
                check_value("o_iaddr", o_iaddr, PC_BASE + 32'(ack_count * 4));  // steps by 4
                i_inst     = prog[ack_count];
                i_ack_inst = 1'b1;
                ack_count++;
            end
        end
    end

    initial begin : retire_monitor
        forever begin
            @(negedge i_clk);
            if (!i_reset && (o_retire_valid || o_illegal)) begin
                if (halted) begin
                    fail_run("instruction retired while i_halt was held high");
                end else if (exp_pc.size() == 0) begin
                    fail_run("retire report with no instruction outstanding");
                end else begin
                    check_value("o_retire_valid", 32'(o_retire_valid), 32'(!exp_ill[0]));
                    check_value("o_illegal", 32'(o_illegal), 32'(exp_ill[0]));
                    check_value("o_retire_pc", o_retire_pc, exp_pc[0]);
                    if (!exp_ill[0]) begin
                        check_value("o_retire_rd", 32'(o_retire_rd), 32'(exp_rd[0]));
                        check_value("o_retire_data", o_retire_data, exp_data[0]);
                    end
                    void'(exp_pc.pop_front());
                    void'(exp_rd.pop_front());
                    void'(exp_data.pop_front());
                    void'(exp_ill.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        repeat (PROG_WORDS * 20 + 200) @(posedge i_clk);
        fail_run("watchdog expired, the core stopped making progress");
    end

    task automatic test_reset();
        int n;
        i_reset = 1'b1;
        repeat (4) begin
            @(posedge i_clk);
            #1;
            check_value("o_stb_inst", 32'(o_stb_inst), 32'd0);
            check_value("o_retire_valid", 32'(o_retire_valid), 32'd0);
            check_value("o_illegal", 32'(o_illegal), 32'd0);
        end
        i_reset = 1'b0;
        n = 0;
        while (o_stb_inst !== 1'b1 && n < 10) begin
            @(negedge i_clk);
            n++;
        end
        if (o_stb_inst !== 1'b1) fail_run("no instruction request after reset release");
        else check_value("o_iaddr", o_iaddr, PC_BASE);
    endtask

    task automatic test_immediates();
        put_i(3'b000, 5'd1, 5'd0, 12'h7ff);   // addi, largest positive
        put_i(3'b000, 5'd2, 5'd0, 12'hff4);   // addi -12
        put_i(3'b010, 5'd3, 5'd2, 12'hff5);   // slti -12 < -11
        put_i(3'b011, 5'd4, 5'd2, 12'h005);   // sltiu sees x2 as huge
        put_i(3'b100, 5'd5, 5'd1, 12'hfff);   // xori -1 inverts
        put_i(3'b110, 5'd6, 5'd2, 12'h0f0);
        put_i(3'b111, 5'd7, 5'd5, 12'h5a5);
        put_i(3'b001, 5'd8, 5'd2, 12'h004);   // slli
        put_i(3'b101, 5'd9, 5'd2, 12'h01c);   // srli 28
        put_i(3'b101, 5'd10, 5'd2, 12'h402);  // srai 2
        put_upper(1'b1, 5'd11, 20'h87654);    // lui
        put_upper(1'b0, 5'd12, 20'h00012);    // auipc
        wait_retired(400);
    endtask

    task automatic test_register_chains();
        put_r(7'h00, 3'b000, 5'd13, 5'd1, 5'd2);    // add
        put_r(7'h20, 3'b000, 5'd14, 5'd13, 5'd1);   // sub, uses x13 right behind
        put_r(7'h00, 3'b001, 5'd15, 5'd1, 5'd3);    // sll
        put_r(7'h00, 3'b010, 5'd16, 5'd14, 5'd15);  // slt
        put_r(7'h00, 3'b011, 5'd17, 5'd14, 5'd15);  // sltu
        put_r(7'h00, 3'b100, 5'd18, 5'd17, 5'd11);  // xor, negative result
        put_r(7'h00, 3'b101, 5'd19, 5'd18, 5'd3);   // srl
        put_r(7'h20, 3'b101, 5'd20, 5'd18, 5'd3);   // sra keeps sign
        put_r(7'h00, 3'b110, 5'd21, 5'd20, 5'd19);  // or
        put_r(7'h00, 3'b111, 5'd22, 5'd21, 5'd12);  // and
        put_r(7'h20, 3'b000, 5'd23, 5'd22, 5'd21);
        wait_retired(400);
    endtask

    task automatic test_x0();
        put_i(3'b000, 5'd0, 5'd1, 12'h005);          // write to x0 is dropped
        put_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd2);
        put_r(7'h00, 3'b000, 5'd24, 5'd0, 5'd0);     // x0 + x0
        put_i(3'b110, 5'd25, 5'd0, 12'h123);
        wait_retired(200);
    endtask

    task automatic test_backpressure();
        int base;
        int n;
        @(posedge i_clk);
        #1;
        i_halt = 1'b1;
        halted = 1'b1;
        base   = ack_count;
        put_i(3'b000, 5'd26, 5'd0, 12'h003);
        put_r(7'h00, 3'b000, 5'd27, 5'd26, 5'd26);
        put_r(7'h20, 3'b000, 5'd28, 5'd27, 5'd1);
        put_r(7'h00, 3'b100, 5'd29, 5'd28, 5'd26);
        put_i(3'b001, 5'd30, 5'd29, 12'h003);
        put_i(3'b101, 5'd31, 5'd30, 12'h401);
        put_i(3'b000, 5'd26, 5'd31, 12'hf9c);        // -100
        put_r(7'h00, 3'b111, 5'd27, 5'd26, 5'd2);
        n = 0;
        while (ack_count - base < QUEUE_DEPTH + 1 && n < 200) begin
            @(negedge i_clk);
            n++;
        end
        if (ack_count - base < QUEUE_DEPTH + 1) begin
            fail_run("core stopped fetching before its queue was full");
        end else begin
            repeat (10) @(negedge i_clk);           // fetch must stay parked
            check_value("i_ack_inst count", 32'(ack_count - base), 32'(QUEUE_DEPTH + 1));
        end
        @(posedge i_clk);
        #1;
        i_halt = 1'b0;
        halted = 1'b0;
        wait_retired(400);
    endtask

    task automatic test_illegal();
        add_word(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd5), 1'b1, 5'd5, 32'd0);  // mul
        put_r(7'h00, 3'b000, 5'd6, 5'd5, 5'd0);      // x5 untouched
        add_word(32'h0000_2083, 1'b1, 5'd1, 32'd0);  // lw x1
        add_word(32'h0000_0073, 1'b1, 5'd0, 32'd0);  // ecall
        put_i(3'b000, 5'd7, 5'd1, 12'h000);          // x1 untouched
        wait_retired(300);
    endtask

    initial begin : main_sequence
        i_reset    = 1'b1;
        i_inst     = 32'd0;
        i_ack_inst = 1'b0;
        i_halt     = 1'b0;
        prog_len   = 0;
        ack_count  = 0;
        halted     = 1'b0;
        lcg_state  = 32'h21c8;
        foreach (ref_regs[i]) ref_regs[i] = 32'd0;
        test_reset();
        test_immediates();
        test_register_chains();
        test_x0();
        test_backpressure();
        test_illegal();
        if (exp_pc.size() != 0) begin
            fail_run("instructions left outstanding at end of run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: rv32i_core.f
rtl/rv32i_pkg.sv
rtl/rv32i_decoded_if.sv
rtl/rv32i_fetch_decode.sv
rtl/rv32i_inst_queue.sv
rtl/rv32i_execute.sv
rtl/rv32i_core.sv
tb/rv32i_core_sva.sv
tb/tb_rv32i_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = tb_rv32i_core
FILELIST  = rv32i_core.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "simulation run failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
